//--- source/ldpc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LDPC check-node definitions
// Degree, stage latencies and configuration register addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ldpc_pkg;

    // Edges per check node, fixed by the eight-input minimum tree
    localparam int CHECK_DEGREE = 8;

    // Cycles through one minimum tree
    localparam int MINIMUM_LATENCY = 3;

    // Cycles from i_valid to o_valid
    // 1 sign/magnitude + 2 x 3 minimum trees + 1 message update
    localparam int PIPELINE_LATENCY = 8;

    // Configuration register addresses
    typedef enum logic [0:0] {
        CONFIG_OFFSET = 1'b0,
        CONFIG_LIMIT  = 1'b1
    } config_address_t;

endpackage : ldpc_pkg

//--- source/ldpc_offset_config.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Offset min-sum configuration registers
// Holds the magnitude offset and the output magnitude limit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`default_nettype none

module ldpc_offset_config #(
    parameter integer MAGNITUDE_WIDTH = 7
) (
    input  wire logic                          i_clock,
    input  wire logic                          i_reset,
    input  wire logic                          i_config_write,
    input  wire ldpc_pkg::config_address_t     i_config_address,
    input  wire logic [MAGNITUDE_WIDTH-1:0]    i_config_data,
    output      logic [MAGNITUDE_WIDTH-1:0]    o_offset,
    output      logic [MAGNITUDE_WIDTH-1:0]    o_limit
);

    // Offset defaults to plain min-sum, limit to no clamping
    always_ff @(posedge i_clock) begin
        if (i_reset == 1'b1) begin
            o_offset <= '0;
            o_limit  <= '1;
        end else if (i_config_write == 1'b1) begin
            case (i_config_address)
                ldpc_pkg::CONFIG_OFFSET: begin
                    o_offset <= i_config_data;
                end
                ldpc_pkg::CONFIG_LIMIT: begin
                    o_limit <= i_config_data;
                end
            endcase
        end
    end

endmodule : ldpc_offset_config

`default_nettype wire

//--- source/ldpc_sign_magnitude.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sign/magnitude split of eight LLR messages
// Registers saturated magnitudes, signs and sign parity
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`default_nettype none

module ldpc_sign_magnitude #(
    parameter integer LLR_WIDTH       = 8,
    parameter integer MAGNITUDE_WIDTH = 7
) (
    input  wire logic                                                i_clock,
    input  wire logic                                                i_reset,
    input  wire logic                                                i_valid,
    input  wire logic [ldpc_pkg::CHECK_DEGREE*LLR_WIDTH-1:0]         i_llr,
    output      logic                                                o_valid,
    output      logic [ldpc_pkg::CHECK_DEGREE*MAGNITUDE_WIDTH-1:0]   o_magnitude,
    output      logic [ldpc_pkg::CHECK_DEGREE-1:0]                   o_sign,
    output      logic                                                o_parity
);

    logic [ldpc_pkg::CHECK_DEGREE*MAGNITUDE_WIDTH-1:0] magnitude_next;
    logic [ldpc_pkg::CHECK_DEGREE-1:0]                 sign_next;
    logic [MAGNITUDE_WIDTH-1:0]                        low_bits [ldpc_pkg::CHECK_DEGREE];

    always_comb begin
        for (int k = 0; k < ldpc_pkg::CHECK_DEGREE; k++) begin
            sign_next[k] = i_llr[k*LLR_WIDTH + LLR_WIDTH - 1];
            low_bits[k]  = i_llr[k*LLR_WIDTH +: MAGNITUDE_WIDTH];
            if (sign_next[k] == 1'b0) begin
                magnitude_next[k*MAGNITUDE_WIDTH +: MAGNITUDE_WIDTH] = low_bits[k];
            end else if (low_bits[k] == '0) begin
                // Most negative value has no positive twin, saturate
                magnitude_next[k*MAGNITUDE_WIDTH +: MAGNITUDE_WIDTH] = '1;
            end else begin
                magnitude_next[k*MAGNITUDE_WIDTH +: MAGNITUDE_WIDTH] = ~low_bits[k] + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset == 1'b1) begin
            o_valid     <= 1'b0;
            o_magnitude <= '0;
            o_sign      <= '0;
            o_parity    <= 1'b0;
        end else begin
            o_valid     <= i_valid;
            o_magnitude <= magnitude_next;
            o_sign      <= sign_next;
            o_parity    <= ^sign_next;
        end
    end

endmodule : ldpc_sign_magnitude

`default_nettype wire

//--- source/ldpc_minimum.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Unsigned minimum of eight values in three cycles
// Also returns the one-hot location of the winner
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`default_nettype none

module ldpc_minimum #(
    parameter integer WIDTH = 16
) (
    input  wire logic               i_clock,
    input  wire logic               i_reset,
    input  wire logic [8*WIDTH-1:0] i_in_data,
    output      logic [WIDTH-1:0]   o_out_data,
    output      logic [7:0]         o_min_location
);

    // Input lanes, lane 0 in the low bits
    logic [WIDTH-1:0] lane [8];

    // Stage 0, four pairs
    logic [3:0]       pair_test;
    logic [WIDTH-1:0] pair_min_r0 [4];
    logic [1:0]       pair_loc_r0 [4];

    // Stage 1, two quads
    logic [1:0]       quad_test;
    logic [WIDTH-1:0] quad_min_r1 [2];
    logic [3:0]       quad_loc_r1 [2];

    // Stage 2, final pick
    logic             final_test;

    // Strict less-than, so a tie goes to the higher-indexed side
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            lane[i] = i_in_data[i*WIDTH +: WIDTH];
        end
        for (int p = 0; p < 4; p++) begin
            pair_test[p] = (lane[2*p] < lane[2*p+1]);
        end
        for (int q = 0; q < 2; q++) begin
            quad_test[q] = (pair_min_r0[2*q] < pair_min_r0[2*q+1]);
        end
        final_test = (quad_min_r1[0] < quad_min_r1[1]);
    end

    always_ff @(posedge i_clock) begin
        if (i_reset == 1'b1) begin
            for (int p = 0; p < 4; p++) begin
                pair_min_r0[p] <= '0;
                pair_loc_r0[p] <= 2'b00;
            end
            for (int q = 0; q < 2; q++) begin
                quad_min_r1[q] <= '0;
                quad_loc_r1[q] <= 4'b0000;
            end
            o_out_data     <= '0;
            o_min_location <= 8'h00;
        end else begin
            // Stage 0, each pair uses its own comparison
            for (int p = 0; p < 4; p++) begin
                pair_min_r0[p] <= pair_test[p] ? lane[2*p] : lane[2*p+1];
                pair_loc_r0[p] <= pair_test[p] ? 2'b01 : 2'b10;
            end

            // Stage 1
            for (int q = 0; q < 2; q++) begin
                quad_min_r1[q] <= quad_test[q] ? pair_min_r0[2*q] : pair_min_r0[2*q+1];
                quad_loc_r1[q] <= quad_test[q] ? {2'b00, pair_loc_r0[2*q]}
                                               : {pair_loc_r0[2*q+1], 2'b00};
            end

            // Stage 2
            o_out_data     <= final_test ? quad_min_r1[0] : quad_min_r1[1];
            o_min_location <= final_test ? {4'b0000, quad_loc_r1[0]}
                                         : {quad_loc_r1[1], 4'b0000};
        end
    end

endmodule : ldpc_minimum

`default_nettype wire

//--- source/ldpc_delay_line.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-depth register chain for any payload type
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`default_nettype none

module ldpc_delay_line #(
    parameter type    PAYLOAD_TYPE = logic [7:0],
    parameter integer DEPTH        = 3
) (
    input  wire logic        i_clock,
    input  wire logic        i_reset,
    input  wire PAYLOAD_TYPE i_data,
    output      PAYLOAD_TYPE o_data
);

    PAYLOAD_TYPE stage_q [DEPTH];

    always_ff @(posedge i_clock) begin
        if (i_reset == 1'b1) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= i_data;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign o_data = stage_q[DEPTH-1];

endmodule : ldpc_delay_line

`default_nettype wire

//--- source/ldpc_min_pair.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// First and second minimum of eight magnitudes
// Two minimum trees in series, second one on a masked copy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`default_nettype none

module ldpc_min_pair #(
    parameter integer MAGNITUDE_WIDTH = 7
) (
    input  wire logic                                              i_clock,
    input  wire logic                                              i_reset,
    input  wire logic [ldpc_pkg::CHECK_DEGREE*MAGNITUDE_WIDTH-1:0] i_magnitude,
    output      logic [MAGNITUDE_WIDTH-1:0]                        o_min1,
    output      logic [MAGNITUDE_WIDTH-1:0]                        o_min2,
    output      logic [ldpc_pkg::CHECK_DEGREE-1:0]                 o_location
);

    localparam integer VECTOR_WIDTH = ldpc_pkg::CHECK_DEGREE * MAGNITUDE_WIDTH;
    localparam integer FIRST_WIDTH  = MAGNITUDE_WIDTH + ldpc_pkg::CHECK_DEGREE;

    typedef logic [VECTOR_WIDTH-1:0] vector_t;
    typedef logic [FIRST_WIDTH-1:0]  first_t;

    logic [MAGNITUDE_WIDTH-1:0]        min1_early;
    logic [ldpc_pkg::CHECK_DEGREE-1:0] location_early;
    vector_t                           magnitude_delayed;
    vector_t                           magnitude_masked;
    first_t                            first_delayed;

    ldpc_minimum #(
        .WIDTH(MAGNITUDE_WIDTH)
    ) first_tree (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_in_data      (i_magnitude),
        .o_out_data     (min1_early),
        .o_min_location (location_early)
    );

    // Keeps the magnitudes in step with the first tree
    ldpc_delay_line #(
        .PAYLOAD_TYPE (vector_t),
        .DEPTH        (ldpc_pkg::MINIMUM_LATENCY)
    ) magnitude_delay (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_data  (i_magnitude),
        .o_data  (magnitude_delayed)
    );

    // Winner forced to all ones so the second tree finds the runner-up
    always_comb begin
        for (int k = 0; k < ldpc_pkg::CHECK_DEGREE; k++) begin
            magnitude_masked[k*MAGNITUDE_WIDTH +: MAGNITUDE_WIDTH] =
                location_early[k] ? {MAGNITUDE_WIDTH{1'b1}}
                                  : magnitude_delayed[k*MAGNITUDE_WIDTH +: MAGNITUDE_WIDTH];
        end
    end

    ldpc_minimum #(
        .WIDTH(MAGNITUDE_WIDTH)
    ) second_tree (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_in_data      (magnitude_masked),
        .o_out_data     (o_min2),
        .o_min_location ()
    );

    ldpc_delay_line #(
        .PAYLOAD_TYPE (first_t),
        .DEPTH        (ldpc_pkg::MINIMUM_LATENCY)
    ) first_delay (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_data  ({min1_early, location_early}),
        .o_data  (first_delayed)
    );

    assign o_min1     = first_delayed[FIRST_WIDTH-1 -: MAGNITUDE_WIDTH];
    assign o_location = first_delayed[ldpc_pkg::CHECK_DEGREE-1:0];

endmodule : ldpc_min_pair

`default_nettype wire

//--- source/ldpc_message_update.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Outgoing check-to-variable messages
// Offset, floor, limit clamp and extrinsic sign per edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`default_nettype none

module ldpc_message_update #(
    parameter integer MAGNITUDE_WIDTH = 7
) (
    input  wire logic                                                  i_clock,
    input  wire logic                                                  i_reset,
    input  wire logic                                                  i_valid,
    input  wire logic [MAGNITUDE_WIDTH-1:0]                            i_min1,
    input  wire logic [MAGNITUDE_WIDTH-1:0]                            i_min2,
    input  wire logic [ldpc_pkg::CHECK_DEGREE-1:0]                     i_location,
    input  wire logic [ldpc_pkg::CHECK_DEGREE-1:0]                     i_sign,
    input  wire logic                                                  i_parity,
    input  wire logic [MAGNITUDE_WIDTH-1:0]                            i_offset,
    input  wire logic [MAGNITUDE_WIDTH-1:0]                            i_limit,
    output      logic                                                  o_valid,
    output      logic [ldpc_pkg::CHECK_DEGREE*(MAGNITUDE_WIDTH+1)-1:0] o_message
);

    localparam integer LLR_WIDTH = MAGNITUDE_WIDTH + 1;

    logic [MAGNITUDE_WIDTH-1:0]                  base    [ldpc_pkg::CHECK_DEGREE];
    logic [MAGNITUDE_WIDTH-1:0]                  reduced [ldpc_pkg::CHECK_DEGREE];
    logic [MAGNITUDE_WIDTH-1:0]                  clamped [ldpc_pkg::CHECK_DEGREE];
    logic [ldpc_pkg::CHECK_DEGREE*LLR_WIDTH-1:0] message_next;

    always_comb begin
        for (int k = 0; k < ldpc_pkg::CHECK_DEGREE; k++) begin
            // Own edge holds min1, so it sees min2 instead
            base[k]    = i_location[k] ? i_min2 : i_min1;
            reduced[k] = (base[k] > i_offset) ? base[k] - i_offset : '0;
            clamped[k] = (reduced[k] > i_limit) ? i_limit : reduced[k];
            // Parity XOR own sign leaves the product of the other seven
            if ((i_parity ^ i_sign[k]) == 1'b1) begin
                message_next[k*LLR_WIDTH +: LLR_WIDTH] = ~{1'b0, clamped[k]} + 1'b1;
            end else begin
                message_next[k*LLR_WIDTH +: LLR_WIDTH] = {1'b0, clamped[k]};
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset == 1'b1) begin
            o_valid   <= 1'b0;
            o_message <= '0;
        end else begin
            o_valid   <= i_valid;
            o_message <= message_next;
        end
    end

endmodule : ldpc_message_update

`default_nettype wire

//--- source/ldpc_check_node.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Offset min-sum check node, degree 8
// Fully pipelined, 8 cycles from i_valid to o_valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`default_nettype none

module ldpc_check_node #(
    parameter integer LLR_WIDTH = 8
) (
    input  wire logic                                            i_clock,
    input  wire logic                                            i_reset,
    input  wire logic [ldpc_pkg::CHECK_DEGREE*LLR_WIDTH-1:0]     i_llr,
    input  wire logic                                            i_valid,
    output      logic [ldpc_pkg::CHECK_DEGREE*LLR_WIDTH-1:0]     o_message,
    output      logic                                            o_valid,
    input  wire logic                                            i_config_write,
    input  wire ldpc_pkg::config_address_t                       i_config_address,
    input  wire logic [LLR_WIDTH-2:0]                            i_config_data
);

    localparam integer MAGNITUDE_WIDTH = LLR_WIDTH - 1;

    // Valid, parity and signs ride together past the minimum trees
    typedef logic [ldpc_pkg::CHECK_DEGREE+1:0] sign_payload_t;

    logic [MAGNITUDE_WIDTH-1:0]                        offset;
    logic [MAGNITUDE_WIDTH-1:0]                        limit;
    logic                                              split_valid;
    logic [ldpc_pkg::CHECK_DEGREE*MAGNITUDE_WIDTH-1:0] split_magnitude;
    logic [ldpc_pkg::CHECK_DEGREE-1:0]                 split_sign;
    logic                                              split_parity;
    logic [MAGNITUDE_WIDTH-1:0]                        min1;
    logic [MAGNITUDE_WIDTH-1:0]                        min2;
    logic [ldpc_pkg::CHECK_DEGREE-1:0]                 location;
    sign_payload_t                                     sign_delayed;

    ldpc_offset_config #(
        .MAGNITUDE_WIDTH(MAGNITUDE_WIDTH)
    ) config_regs (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_config_write   (i_config_write),
        .i_config_address (i_config_address),
        .i_config_data    (i_config_data),
        .o_offset         (offset),
        .o_limit          (limit)
    );

    ldpc_sign_magnitude #(
        .LLR_WIDTH       (LLR_WIDTH),
        .MAGNITUDE_WIDTH (MAGNITUDE_WIDTH)
    ) sign_split (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_valid     (i_valid),
        .i_llr       (i_llr),
        .o_valid     (split_valid),
        .o_magnitude (split_magnitude),
        .o_sign      (split_sign),
        .o_parity    (split_parity)
    );

    ldpc_min_pair #(
        .MAGNITUDE_WIDTH(MAGNITUDE_WIDTH)
    ) min_pair (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_magnitude (split_magnitude),
        .o_min1      (min1),
        .o_min2      (min2),
        .o_location  (location)
    );

    // Matches the two minimum trees, six cycles
    ldpc_delay_line #(
        .PAYLOAD_TYPE (sign_payload_t),
        .DEPTH        (ldpc_pkg::PIPELINE_LATENCY - 2)
    ) sign_delay (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_data  ({split_valid, split_parity, split_sign}),
        .o_data  (sign_delayed)
    );

    ldpc_message_update #(
        .MAGNITUDE_WIDTH(MAGNITUDE_WIDTH)
    ) message_update (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_valid    (sign_delayed[ldpc_pkg::CHECK_DEGREE+1]),
        .i_min1     (min1),
        .i_min2     (min2),
        .i_location (location),
        .i_sign     (sign_delayed[ldpc_pkg::CHECK_DEGREE-1:0]),
        .i_parity   (sign_delayed[ldpc_pkg::CHECK_DEGREE]),
        .i_offset   (offset),
        .i_limit    (limit),
        .o_valid    (o_valid),
        .o_message  (o_message)
    );

endmodule : ldpc_check_node

`default_nettype wire

//--- verification/ldpc_check_node_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the offset min-sum check node
// Reference model, expected queue and concurrent checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ldpc_check_node_tb;

    localparam int LLR_WIDTH     = 8;
    localparam int DEGREE        = ldpc_pkg::CHECK_DEGREE;
    localparam int MAGNITUDE_MAX = (1 << (LLR_WIDTH - 1)) - 1;
    localparam int LATENCY       = 8;
    localparam int QUEUE_DEPTH   = 64;
    localparam int WAIT_LIMIT    = 60;

    logic                           i_clock = 1'b0;
    logic                           i_reset;
    logic [DEGREE*LLR_WIDTH-1:0]    i_llr;
    logic                           i_valid;
    logic                           i_config_write;
    ldpc_pkg::config_address_t      i_config_address;
    logic [LLR_WIDTH-2:0]           i_config_data;
    logic [DEGREE*LLR_WIDTH-1:0]    o_message;
    logic                           o_valid;

    // Expected queue holds one entry per accepted item
    logic [DEGREE*LLR_WIDTH-1:0]    expected_message [QUEUE_DEPTH];
    int unsigned                    expected_cycle   [QUEUE_DEPTH];
    int unsigned                    push_count = 0;
    int unsigned                    pop_count  = 0;
    int unsigned                    cycle_count = 0;
    int unsigned                    in_flight;
    logic [DEGREE*LLR_WIDTH-1:0]    head_message;
    int unsigned                    head_cycle;

    // Configuration as the model sees it
    int                             offset_model = 0;
    int                             limit_model  = MAGNITUDE_MAX;

    logic [31:0]                    lfsr_state = 32'hb022;
    logic [DEGREE*LLR_WIDTH-1:0]    random_llr;
    int                             value_errors    = 0;
    int                             latency_errors  = 0;
    int                             protocol_errors = 0;
    int                             timeout_errors  = 0;

    ldpc_check_node #(
        .LLR_WIDTH(LLR_WIDTH)
    ) uut (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_llr            (i_llr),
        .i_valid          (i_valid),
        .o_message        (o_message),
        .o_valid          (o_valid),
        .i_config_write   (i_config_write),
        .i_config_address (i_config_address),
        .i_config_data    (i_config_data)
    );

    always #50 i_clock = ~i_clock;

    assign in_flight    = push_count - pop_count;
    assign head_message = expected_message[pop_count % QUEUE_DEPTH];
    assign head_cycle   = expected_cycle[pop_count % QUEUE_DEPTH];

    // Each edge takes the smallest other magnitude and the product of the other signs
    function automatic logic [DEGREE*LLR_WIDTH-1:0] model_messages(
        input logic [DEGREE*LLR_WIDTH-1:0] llr,
        input int                          offset_value,
        input int                          limit_value
    );
        int                          magnitude [DEGREE];
        logic                        sign [DEGREE];
        logic [DEGREE*LLR_WIDTH-1:0] result;
        int                          base;
        int                          value;
        logic                        negative;
        for (int k = 0; k < DEGREE; k++) begin
            value        = $signed(llr[k*LLR_WIDTH +: LLR_WIDTH]);
            sign[k]      = (value < 0);
            magnitude[k] = (value < 0) ? -value : value;
            if (magnitude[k] > MAGNITUDE_MAX) begin
                magnitude[k] = MAGNITUDE_MAX;
            end
        end
        for (int k = 0; k < DEGREE; k++) begin
            base     = MAGNITUDE_MAX + 1;
            negative = 1'b0;
            for (int j = 0; j < DEGREE; j++) begin
                if (j != k) begin
                    if (magnitude[j] < base) begin
                        base = magnitude[j];
                    end
                    negative = negative ^ sign[j];
                end
            end
            base = base - offset_value;
            if (base < 0) begin
                base = 0;
            end
            if (base > limit_value) begin
                base = limit_value;
            end
            value = negative ? -base : base;
            result[k*LLR_WIDTH +: LLR_WIDTH] = value[LLR_WIDTH-1:0];
        end
        return result;
    endfunction

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic draw_llr(output logic [DEGREE*LLR_WIDTH-1:0] value);
        for (int i = 0; i < DEGREE * LLR_WIDTH; i++) begin
            value[i]   = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Accepted items go into the queue and outputs retire them
    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (i_reset == 1'b1) begin
            pop_count    <= push_count;
            offset_model <= 0;
            limit_model  <= MAGNITUDE_MAX;
        end else begin
            if (i_valid == 1'b1) begin
                expected_message[push_count % QUEUE_DEPTH] <=
                    model_messages(i_llr, offset_model, limit_model);
                expected_cycle[push_count % QUEUE_DEPTH] <= cycle_count;
                push_count <= push_count + 1;
            end
            if (o_valid == 1'b1 && in_flight != 0) begin
                pop_count <= pop_count + 1;
            end
            if (i_config_write == 1'b1) begin
                if (i_config_address == ldpc_pkg::CONFIG_OFFSET) begin
                    offset_model <= i_config_data;
                end else begin
                    limit_model <= i_config_data;
                end
            end
        end
    end

    no_spurious_valid: assert property (@(posedge i_clock) disable iff (i_reset)
        o_valid |-> (in_flight != 0))
    else begin
        protocol_errors = protocol_errors + 1;
        $display("error at %0t: o_valid expected 0 actual %b", $time, $sampled(o_valid));
    end

    message_matches: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_valid && in_flight != 0) |-> (o_message == head_message))
    else begin
        value_errors = value_errors + 1;
        $display("error at %0t: o_message expected %h actual %h",
                 $time, $sampled(head_message), $sampled(o_message));
    end

    latency_matches: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_valid && in_flight != 0) |-> (cycle_count - head_cycle == LATENCY))
    else begin
        latency_errors = latency_errors + 1;
        $display("error at %0t: o_valid latency expected %0d actual %0d",
                 $time, LATENCY, $sampled(cycle_count) - $sampled(head_cycle));
    end

    output_on_time: assert property (@(posedge i_clock) disable iff (i_reset)
        (in_flight != 0 && cycle_count - head_cycle == LATENCY) |-> o_valid)
    else begin
        latency_errors = latency_errors + 1;
        $display("error at %0t: o_valid expected 1 actual %b", $time, $sampled(o_valid));
    end

    task automatic next_cycle();
        @(posedge i_clock);
        #1;
    endtask

    task automatic send_item(input logic [DEGREE*LLR_WIDTH-1:0] llr);
        i_llr   = llr;
        i_valid = 1'b1;
        next_cycle();
        i_valid = 1'b0;
    endtask

    task automatic send_random(input int count);
        for (int n = 0; n < count; n++) begin
            draw_llr(random_llr);
            send_item(random_llr);
        end
    endtask

    task automatic write_config(input ldpc_pkg::config_address_t address,
                                input logic [LLR_WIDTH-2:0] data);
        i_config_write   = 1'b1;
        i_config_address = address;
        i_config_data    = data;
        next_cycle();
        i_config_write   = 1'b0;
    endtask

    task automatic apply_reset();
        i_reset = 1'b1;
        repeat (3) next_cycle();
        i_reset = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (in_flight != 0 && waited < WAIT_LIMIT) begin
            next_cycle();
            waited = waited + 1;
        end
        if (in_flight != 0) begin
            timeout_errors = timeout_errors + 1;
            $display("Timed out at %0t with %0d items still in flight", $time, in_flight);
        end
    endtask

    initial begin
        i_reset          = 1'b1;
        i_llr            = '0;
        i_valid          = 1'b0;
        i_config_write   = 1'b0;
        i_config_address = ldpc_pkg::CONFIG_OFFSET;
        i_config_data    = '0;
        apply_reset();

        // One item with the default configuration after a quiet pipeline
        repeat (5) next_cycle();
        send_random(1);
        wait_drained();

        // Back-to-back burst keeps several items in flight
        send_random(40);
        wait_drained();

        write_config(ldpc_pkg::CONFIG_OFFSET, 7'd2);
        write_config(ldpc_pkg::CONFIG_LIMIT, 7'd5);
        send_random(20);
        wait_drained();

        // Edge values under plain min-sum
        write_config(ldpc_pkg::CONFIG_OFFSET, 7'd0);
        write_config(ldpc_pkg::CONFIG_LIMIT, 7'h7f);
        send_item({8{8'h80}});
        send_item({8'h05, 8'h80, 8'h40, 8'h33, 8'h7f, 8'h21, 8'h12, 8'h09});
        send_item({8{8'd20}});
        send_item({8{8'hec}});
        send_item('0);
        send_item({8'h11, 8'h07, 8'hf3, 8'h1c, 8'h2a, 8'h09, 8'h3e, 8'h15});
        wait_drained();

        // Reset in mid-stream drops the burst and restores the defaults
        write_config(ldpc_pkg::CONFIG_OFFSET, 7'd3);
        write_config(ldpc_pkg::CONFIG_LIMIT, 7'd9);
        send_random(5);
        apply_reset();
        repeat (4) next_cycle();
        send_random(1);
        wait_drained();
        repeat (4) next_cycle();

        $display("Errors: value %0d, latency %0d, protocol %0d, timeout %0d",
                 value_errors, latency_errors, protocol_errors, timeout_errors);
        if (value_errors + latency_errors + protocol_errors + timeout_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : ldpc_check_node_tb

//--- ldpc_check_node.f
source/ldpc_pkg.sv
source/ldpc_offset_config.sv
source/ldpc_sign_magnitude.sv
source/ldpc_minimum.sv
source/ldpc_delay_line.sv
source/ldpc_min_pair.sv
source/ldpc_message_update.sv
source/ldpc_check_node.sv
verification/ldpc_check_node_tb.sv
